//--- rtl/tile_layer_pkg.sv
// Values assume a 9-bit beam, 8x8 tiles, 4bpp planar ROM rows and a 21-bit byte address ROM
package tile_layer_pkg;

    // ========================================
    // Widths
    // ========================================

    // Beam counters as they come from the video timing block
    localparam int unsigned beam_w     = 9;
    // Scroll offsets and scrolled positions carry one extra bit for the wide map
    localparam int unsigned scroll_w   = 10;
    localparam int unsigned index_w    = 13;
    localparam int unsigned rom_addr_w = 21;
    localparam int unsigned pix_w      = 4;
    localparam int unsigned pal_w      = 7;
    // Tile word and ROM row share one width
    localparam int unsigned tile_w     = 32;

    // ========================================
    // Tile word fields
    // ========================================

    // Only code bits 15:0 reach the ROM address
    localparam int unsigned code_lsb  = 0;
    localparam int unsigned code_w    = 16;
    localparam int unsigned pal_lsb   = 16;
    // Priority when the top color bit is set
    localparam int unsigned cp8_bit   = 23;
    // Priority for any opaque pixel
    localparam int unsigned cp15_bit  = 24;
    localparam int unsigned hflip_bit = 25;
    localparam int unsigned vflip_bit = 26;

    // ========================================
    // Slot phases and fetch states
    // ========================================

    // Phase is the low three bits of the flipped scrolled horizontal position
    localparam logic [2:0] ph_index = 3'd0;
    localparam logic [2:0] ph_fetch = 3'd2;
    localparam logic [2:0] ph_load  = 3'd7;

    // Fetch state encodings
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_req  = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;

endpackage

//--- rtl/scroll_counter.sv
// Beam inputs must be stable between pixel enables; flip mirrors only the in-tile phase
`timescale 1ns/1ps

module scroll_counter (
    input  logic                               clk_sys,
    input  logic                               rst_n,
    input  logic                               ce_pix,
    input  logic                               flip,
    input  logic                               wide,
    input  logic [tile_layer_pkg::beam_w-1:0]   ve,
    input  logic [tile_layer_pkg::beam_w-1:0]   he,
    input  logic [tile_layer_pkg::scroll_w-1:0] v_adj,
    input  logic [tile_layer_pkg::scroll_w-1:0] h_adj,
    input  logic [tile_layer_pkg::tile_w-1:0]   tile_data,
    output logic [tile_layer_pkg::index_w-1:0]  tile_index,
    output logic [2:0]                          row,
    output logic                                index_stb,
    output logic                                fetch_stb,
    output logic                                load_stb
);
    import tile_layer_pkg::*;

    // Scrolled positions
    logic [scroll_w-1:0] sv;
    logic [scroll_w-1:0] sh;
    // Position inside the current 8-pixel slot
    logic [2:0]          phase;
    logic [index_w-1:0]  next_index;

    // ========================================
    // Scroll and flip
    // ========================================

    assign sv = {{(scroll_w - beam_w){1'b0}}, ve} + v_adj;
    assign sh = {{(scroll_w - beam_w){1'b0}}, he} + h_adj;

    // With flip the slot is walked backwards, so the phase counts down
    assign phase = sh[2:0] ^ {3{flip}};

    // Pixel row inside the tile, mirrored vertically by the tile word
    assign row = sv[2:0] ^ {3{tile_data[vflip_bit]}};

    // ========================================
    // Map index
    // ========================================

    // Row bits lead in both layouts
    // The narrow map pads the column with a zero so both layouts fill 13 bits
    always_comb begin
        if (wide) begin
            next_index = {sv[8:3], sh[9:3]};
        end else begin
            next_index = {sv[8:3], 1'b0, sh[8:3]};
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            tile_index <= '0;
        end else if (index_stb) begin
            tile_index <= next_index;
        end
    end

    // ========================================
    // Slot strobes
    // ========================================

    // Each strobe lasts one clk_sys cycle because ce_pix does
    assign index_stb = ce_pix && (phase == ph_index);
    assign fetch_stb = ce_pix && (phase == ph_fetch);
    assign load_stb  = ce_pix && (phase == ph_load);

endmodule

//--- rtl/fetch_sequencer.sv
// ROM must answer each single-cycle request with one sdr_rdy before the load phase of the slot
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic                                 fetch_stb,
    input  logic                                 load_stb,
    input  logic [tile_layer_pkg::tile_w-1:0]     tile_data,
    input  logic [2:0]                            row,
    output logic [tile_layer_pkg::rom_addr_w-1:0] sdr_addr,
    output logic                                  sdr_req,
    input  logic [tile_layer_pkg::tile_w-1:0]     sdr_data,
    input  logic                                  sdr_rdy,
    output logic [tile_layer_pkg::tile_w-1:0]     rom_row
);
    import tile_layer_pkg::*;

    logic [1:0] state;
    // A fetch only starts from idle so a stray strobe mid-fetch is ignored
    logic       fetch_go;

    assign fetch_go = fetch_stb && (state == st_idle);

    // The request pulse is simply the one cycle spent in the request state
    assign sdr_req = (state == st_req);

    // ========================================
    // State machine
    // ========================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            rom_row <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch_go) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    // An answer in the request cycle itself finishes the fetch at once
                    state <= sdr_rdy ? st_idle : st_wait;
                end
                st_wait: begin
                    if (sdr_rdy) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            // Capture the graphics row in the cycle the ROM marks it valid
            if (sdr_rdy && (state != st_idle)) begin
                rom_row <= sdr_data;
            end
        end
    end

    // Address stays put from the request until the next fetch starts
    // The ROM is byte addressed so the low two bits stay zero for a whole 32-bit row
    always_ff @(posedge clk_sys) begin
        if (fetch_go) begin
            sdr_addr <= {tile_data[code_lsb +: code_w], row, 2'b00};
        end
    end

    // ========================================
    // Protocol checks
    // ========================================

    a_rdy_before_load: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(load_stb && (state == st_wait)))
        else $error("ROM answer arrived too late, the shifter loaded a stale row");

    a_no_spurious_rdy: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(sdr_rdy && (state == st_idle)))
        else $error("ROM ready seen with no request outstanding");

endmodule

//--- rtl/tile_pixel_pipe.sv
// Pixels of a loaded row appear one slot after their fetch; the board offsets this via h_adj
`timescale 1ns/1ps

module tile_pixel_pipe (
    input  logic                              clk_sys,
    input  logic                              rst_n,
    input  logic                              ce_pix,
    input  logic                              load_stb,
    input  logic                              flip,
    input  logic                              enabled,
    input  logic [tile_layer_pkg::tile_w-1:0]  rom_row,
    input  logic [tile_layer_pkg::tile_w-1:0]  tile_data,
    output logic [tile_layer_pkg::pix_w-1:0]   color,
    output logic                               prio,
    output logic [tile_layer_pkg::pal_w-1:0]   palette
);
    import tile_layer_pkg::*;

    // One 8-bit shift register per bit plane
    // Plane n is byte n of the row
    logic [pix_w-1:0][7:0] planes;
    // Attributes latched with the row
    logic                  cp8;
    logic                  cp15;
    logic                  mirror;
    // Leftmost and rightmost pixel of the planes
    logic [pix_w-1:0]      pix_f;
    logic [pix_w-1:0]      pix_r;
    logic [pix_w-1:0]      pix;

    // ========================================
    // Plane shifters
    // ========================================

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            planes <= '0;
        end else if (load_stb) begin
            planes <= rom_row;
        end else if (ce_pix) begin
            // Mirrored tiles drain from the bottom bit, normal ones from the top
            for (int n = 0; n < pix_w; n++) begin
                if (mirror) begin
                    planes[n] <= {1'b0, planes[n][7:1]};
                end else begin
                    planes[n] <= {planes[n][6:0], 1'b0};
                end
            end
        end
    end

    // Pixel bit n comes from plane n
    always_comb begin
        for (int n = 0; n < pix_w; n++) begin
            pix_f[n] = planes[n][7];
            pix_r[n] = planes[n][0];
        end
    end

    assign pix = mirror ? pix_r : pix_f;

    // ========================================
    // Attribute latch
    // ========================================

    // Latched together with the row so they stay with their pixels for the whole slot
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            palette <= '0;
            cp8     <= 1'b0;
            cp15    <= 1'b0;
            mirror  <= 1'b0;
        end else if (load_stb) begin
            palette <= tile_data[pal_lsb +: pal_w];
            cp8     <= tile_data[cp8_bit];
            cp15    <= tile_data[cp15_bit];
            // Screen flip mirrors every tile on top of its own flag
            mirror  <= tile_data[hflip_bit] ^ flip;
        end
    end

    // ========================================
    // Outputs
    // ========================================

    assign color = enabled ? pix : '0;

    // cp15 beats cp8, and a disabled layer never claims priority
    always_comb begin
        if (!enabled) begin
            prio = 1'b0;
        end else if (cp15) begin
            prio = |pix;
        end else if (cp8) begin
            prio = pix[pix_w-1];
        end else begin
            prio = 1'b0;
        end
    end

endmodule

//--- rtl/tile_layer.sv
// One background layer; map RAM and graphics ROM sit outside, palette lookup and mixing too
`timescale 1ns/1ps

module tile_layer (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic                                 ce_pix,
    input  logic                                 flip,
    input  logic                                 wide,
    input  logic                                 enabled,
    input  logic [tile_layer_pkg::beam_w-1:0]     ve,
    input  logic [tile_layer_pkg::beam_w-1:0]     he,
    input  logic [tile_layer_pkg::scroll_w-1:0]   v_adj,
    input  logic [tile_layer_pkg::scroll_w-1:0]   h_adj,
    input  logic [tile_layer_pkg::tile_w-1:0]     tile_data,
    input  logic [tile_layer_pkg::tile_w-1:0]     sdr_data,
    input  logic                                  sdr_rdy,
    output logic [tile_layer_pkg::index_w-1:0]    tile_index,
    output logic [tile_layer_pkg::rom_addr_w-1:0] sdr_addr,
    output logic                                  sdr_req,
    output logic [tile_layer_pkg::pix_w-1:0]      color,
    output logic                                  prio,
    output logic [tile_layer_pkg::pal_w-1:0]      palette
);
    import tile_layer_pkg::*;

    // Slot timing shared by the fetch and the shifter
    logic              fetch_stb;
    logic              load_stb;
    logic [2:0]        row;
    // Graphics row handed from the fetch to the shifter
    logic [tile_w-1:0] rom_row;

    // The index strobe only paces the map RAM read inside the counter
    scroll_counter i_scroll_counter (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .ce_pix     (ce_pix),
        .flip       (flip),
        .wide       (wide),
        .ve         (ve),
        .he         (he),
        .v_adj      (v_adj),
        .h_adj      (h_adj),
        .tile_data  (tile_data),
        .tile_index (tile_index),
        .row        (row),
        .index_stb  (),
        .fetch_stb  (fetch_stb),
        .load_stb   (load_stb)
    );

    fetch_sequencer i_fetch_sequencer (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .fetch_stb (fetch_stb),
        .load_stb  (load_stb),
        .tile_data (tile_data),
        .row       (row),
        .sdr_addr  (sdr_addr),
        .sdr_req   (sdr_req),
        .sdr_data  (sdr_data),
        .sdr_rdy   (sdr_rdy),
        .rom_row   (rom_row)
    );

    tile_pixel_pipe i_tile_pixel_pipe (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .ce_pix    (ce_pix),
        .load_stb  (load_stb),
        .flip      (flip),
        .enabled   (enabled),
        .rom_row   (rom_row),
        .tile_data (tile_data),
        .color     (color),
        .prio      (prio),
        .palette   (palette)
    );

endmodule

//--- sim/tb_tile_layer_models.sv
// Behavioral map RAM and graphics ROM; contents are hashes, the ROM serves one request at a time
`timescale 1ns/1ps

// ========================================
// Map RAM
// ========================================

module map_ram_model (
    input  logic                              clk_sys,
    input  logic [tile_layer_pkg::index_w-1:0] tile_index,
    output logic [tile_layer_pkg::tile_w-1:0]  tile_data
);
    import tile_layer_pkg::*;

    // Multiply by an odd constant, then fold the top down so the flag bits vary too
    function automatic logic [tile_w-1:0] map_word(input logic [index_w-1:0] idx);
        logic [31:0] h;
        h = {19'd0, idx} * 32'h9e3779b1;
        return h ^ (h >> 15);
    endfunction

    // One registered read, so the word trails the index by one clk_sys cycle
    always @(posedge clk_sys) begin
        tile_data <= map_word(tile_index);
    end

endmodule

// ========================================
// Graphics ROM
// ========================================

module gfx_rom_model (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic                                 sdr_req,
    input  logic [tile_layer_pkg::rom_addr_w-1:0] sdr_addr,
    output logic [tile_layer_pkg::tile_w-1:0]     sdr_data,
    output logic                                  sdr_rdy
);
    import tile_layer_pkg::*;

    integer      seed;
    logic [31:0] rnd;
    // A request is outstanding and wait_left more cycles remain before the answer
    logic        busy;
    logic [2:0]  wait_left;

    function automatic logic [tile_w-1:0] rom_word(input logic [rom_addr_w-1:0] addr);
        logic [31:0] h;
        h = {11'd0, addr} * 32'h85ebca6b;
        return h ^ (h >> 13) ^ 32'h5bd1e995;
    endfunction

    initial seed = 32'hd0f37b73;

    // Latency is 1 to 4 cycles after the request cycle, drawn per request
    always @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            wait_left <= 3'd0;
            sdr_rdy   <= 1'b0;
            sdr_data  <= '0;
        end else begin
            sdr_rdy <= 1'b0;
            if (sdr_req) begin
                rnd = $random(seed);
                if (rnd[1:0] == 2'd0) begin
                    sdr_rdy  <= 1'b1;
                    sdr_data <= rom_word(sdr_addr);
                end else begin
                    busy      <= 1'b1;
                    wait_left <= {1'b0, rnd[1:0]};
                end
            end else if (busy) begin
                // The DUT holds sdr_addr until its next request, so it is still valid here
                if (wait_left == 3'd1) begin
                    sdr_rdy  <= 1'b1;
                    sdr_data <= rom_word(sdr_addr);
                    busy     <= 1'b0;
                end else begin
                    wait_left <= wait_left - 3'd1;
                end
            end
        end
    end

endmodule

//--- sim/tb_tile_layer.sv
// Runs four beam configurations of 64-pixel lines; a pause with ce_pix low separates them
`timescale 1ns/1ps

module tb_tile_layer;
    import tile_layer_pkg::*;

    // ========================================
    // Run length
    // ========================================

    localparam int line_px       = 64;
    localparam int lines_per_cfg = 4;
    localparam int n_cfg         = 4;
    localparam int reset_cycles  = 8;
    localparam int pause_cycles  = 12;
    // Two clk_sys cycles per pixel since ce_pix runs at half rate
    localparam int timeout_cycles = n_cfg * lines_per_cfg * line_px * 2
        + reset_cycles + (n_cfg + 1) * pause_cycles + 200;

    logic                  clk_sys;
    logic                  rst_n;
    logic                  ce_pix;
    logic                  flip;
    logic                  wide;
    logic                  enabled;
    logic [beam_w-1:0]     ve;
    logic [beam_w-1:0]     he;
    logic [scroll_w-1:0]   v_adj;
    logic [scroll_w-1:0]   h_adj;
    logic [tile_w-1:0]     tile_data;
    logic [tile_w-1:0]     sdr_data;
    logic                  sdr_rdy;
    logic [index_w-1:0]    tile_index;
    logic [rom_addr_w-1:0] sdr_addr;
    logic                  sdr_req;
    logic [pix_w-1:0]      color;
    logic                  prio;
    logic [pal_w-1:0]      palette;

    string test_name;
    int    mismatch_count = 0;
    int    protocol_count = 0;
    int    disabled_reqs  = 0;
    int    cycle_count    = 0;

    // Reference model state
    logic [scroll_w-1:0]   ref_sv;
    logic [scroll_w-1:0]   ref_sh;
    logic [2:0]            ref_phase;
    logic                  ev_index;
    logic                  ev_fetch;
    logic                  ev_load;
    logic [index_w-1:0]    exp_index;
    logic                  exp_req;
    logic [rom_addr_w-1:0] exp_addr;
    // Last row the ROM delivered, and the row loaded for display
    logic [tile_w-1:0]     ref_row;
    logic [tile_w-1:0]     exp_row;
    logic [pal_w-1:0]      exp_pal;
    logic                  exp_cp8;
    logic                  exp_cp15;
    logic                  exp_mirror;
    // Pixels shown since the load
    // A count of 8 means the row is used up
    logic [3:0]            exp_pos;
    logic [pix_w-1:0]      exp_pix;
    logic [pix_w-1:0]      exp_color;
    logic                  exp_prio;

    // ========================================
    // DUT and memory models
    // ========================================

    tile_layer i_dut (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .ce_pix     (ce_pix),
        .flip       (flip),
        .wide       (wide),
        .enabled    (enabled),
        .ve         (ve),
        .he         (he),
        .v_adj      (v_adj),
        .h_adj      (h_adj),
        .tile_data  (tile_data),
        .sdr_data   (sdr_data),
        .sdr_rdy    (sdr_rdy),
        .tile_index (tile_index),
        .sdr_addr   (sdr_addr),
        .sdr_req    (sdr_req),
        .color      (color),
        .prio       (prio),
        .palette    (palette)
    );

    map_ram_model i_map_ram (
        .clk_sys    (clk_sys),
        .tile_index (tile_index),
        .tile_data  (tile_data)
    );

    gfx_rom_model i_gfx_rom (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .sdr_req  (sdr_req),
        .sdr_addr (sdr_addr),
        .sdr_data (sdr_data),
        .sdr_rdy  (sdr_rdy)
    );

    initial clk_sys = 1'b0;
    always #5 clk_sys = ~clk_sys;

    // ========================================
    // Reference model
    // ========================================

    // Same hash as the ROM contents, written out from the data rule
    function automatic logic [tile_w-1:0] expected_rom_row(input logic [rom_addr_w-1:0] addr);
        logic [31:0] h;
        h = {11'd0, addr} * 32'h85ebca6b;
        return h ^ (h >> 13) ^ 32'h5bd1e995;
    endfunction

    // Map row is tile row 0..63 and the column spans 128 tiles wide or 64 narrow
    function automatic logic [index_w-1:0] expected_index(input logic [scroll_w-1:0] sv,
                                                          input logic [scroll_w-1:0] sh,
                                                          input logic              w);
        int map_row;
        int map_col;
        map_row = (int'(sv) / 8) % 64;
        map_col = w ? (int'(sh) / 8) % 128 : (int'(sh) / 8) % 64;
        return index_w'(map_row * 128 + map_col);
    endfunction

    // Pixel pos of a row, counted from the left edge or from the right when mirrored
    function automatic logic [pix_w-1:0] pixel_at(input logic [tile_w-1:0] r,
                                                  input logic [3:0]        pos,
                                                  input logic              m);
        logic [pix_w-1:0] p;
        int               bit_sel;
        p = '0;
        if (pos < 4'd8) begin
            bit_sel = m ? int'(pos) : 7 - int'(pos);
            for (int n = 0; n < pix_w; n++) begin
                p[n] = r[8 * n + bit_sel];
            end
        end
        return p;
    endfunction

    assign ref_sv    = {1'b0, ve} + v_adj;
    assign ref_sh    = {1'b0, he} + h_adj;
    assign ref_phase = ref_sh[2:0] ^ {3{flip}};
    assign ev_index  = ce_pix && (ref_phase == ph_index);
    assign ev_fetch  = ce_pix && (ref_phase == ph_fetch);
    assign ev_load   = ce_pix && (ref_phase == ph_load);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            exp_index  <= '0;
            exp_req    <= 1'b0;
            exp_addr   <= '0;
            ref_row    <= '0;
            exp_row    <= '0;
            exp_pal    <= '0;
            exp_cp8    <= 1'b0;
            exp_cp15   <= 1'b0;
            exp_mirror <= 1'b0;
            exp_pos    <= 4'd0;
        end else begin
            if (ev_index) begin
                exp_index <= expected_index(ref_sv, ref_sh, wide);
            end
            // The request follows the fetch phase by exactly one cycle
            exp_req <= ev_fetch;
            if (ev_fetch) begin
                exp_addr <= {tile_data[15:0], ref_sv[2:0] ^ {3{tile_data[26]}}, 2'b00};
            end
            if (sdr_rdy) begin
                ref_row <= expected_rom_row(exp_addr);
            end
            if (ev_load) begin
                exp_row    <= ref_row;
                exp_pal    <= tile_data[22:16];
                exp_cp8    <= tile_data[23];
                exp_cp15   <= tile_data[24];
                exp_mirror <= tile_data[25] ^ flip;
                exp_pos    <= 4'd0;
            end else if (ce_pix && (exp_pos < 4'd8)) begin
                exp_pos <= exp_pos + 4'd1;
            end
        end
    end

    assign exp_pix   = pixel_at(exp_row, exp_pos, exp_mirror);
    assign exp_color = enabled ? exp_pix : '0;

    always_comb begin
        if (!enabled) begin
            exp_prio = 1'b0;
        end else if (exp_cp15) begin
            exp_prio = exp_color != '0;
        end else if (exp_cp8) begin
            exp_prio = exp_color[3];
        end else begin
            exp_prio = 1'b0;
        end
    end

    // ========================================
    // Checks
    // ========================================

    a_index: assert property (@(posedge clk_sys) disable iff (!rst_n) tile_index == exp_index)
        else begin
            mismatch_count++;
            $display("MISMATCH %s tile_index expected %h actual %h", test_name,
                     $sampled(exp_index), $sampled(tile_index));
        end

    a_req: assert property (@(posedge clk_sys) disable iff (!rst_n) sdr_req == exp_req)
        else begin
            mismatch_count++;
            $display("MISMATCH %s sdr_req expected %b actual %b", test_name,
                     $sampled(exp_req), $sampled(sdr_req));
        end

    a_addr: assert property (@(posedge clk_sys) disable iff (!rst_n)
        sdr_req |-> sdr_addr == exp_addr)
        else begin
            mismatch_count++;
            $display("MISMATCH %s sdr_addr expected %h actual %h", test_name,
                     $sampled(exp_addr), $sampled(sdr_addr));
        end

    a_color: assert property (@(posedge clk_sys) disable iff (!rst_n) color == exp_color)
        else begin
            mismatch_count++;
            $display("MISMATCH %s color expected %h actual %h", test_name,
                     $sampled(exp_color), $sampled(color));
        end

    a_prio: assert property (@(posedge clk_sys) disable iff (!rst_n) prio == exp_prio)
        else begin
            mismatch_count++;
            $display("MISMATCH %s prio expected %b actual %b", test_name,
                     $sampled(exp_prio), $sampled(prio));
        end

    a_palette: assert property (@(posedge clk_sys) disable iff (!rst_n) palette == exp_pal)
        else begin
            mismatch_count++;
            $display("MISMATCH %s palette expected %h actual %h", test_name,
                     $sampled(exp_pal), $sampled(palette));
        end

    // Fetching must go on while the layer is blanked
    always @(posedge clk_sys) begin
        if (rst_n && !enabled && sdr_req) begin
            disabled_reqs++;
        end
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the stimulus never finished", timeout_cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    // he moves on each enable, ve at the end of the line
    task automatic run_lines(input int n_lines);
        for (int l = 0; l < n_lines; l++) begin
            for (int p = 0; p < line_px; p++) begin
                @(posedge clk_sys);
                ce_pix <= 1'b1;
                he     <= beam_w'(p);
                @(posedge clk_sys);
                ce_pix <= 1'b0;
            end
            ve <= ve + 1'b1;
        end
    endtask

    // Long enough for any ROM answer in flight to land before the beam jumps
    task automatic pause_pixels();
        ce_pix <= 1'b0;
        repeat (pause_cycles) @(posedge clk_sys);
        ve <= '0;
        he <= '0;
    endtask

    initial begin
        rst_n     = 1'b0;
        ce_pix    = 1'b0;
        flip      = 1'b0;
        wide      = 1'b0;
        enabled   = 1'b1;
        ve        = '0;
        he        = '0;
        v_adj     = '0;
        h_adj     = '0;
        test_name = "reset";
        repeat (reset_cycles) @(posedge clk_sys);
        rst_n <= 1'b1;
        // Nothing may be fetched or shown in this idle window without pixel enables
        pause_pixels();

        test_name = "normal";
        run_lines(lines_per_cfg);

        pause_pixels();
        test_name = "flip";
        flip  <= 1'b1;
        v_adj <= 10'd3;
        run_lines(lines_per_cfg);

        pause_pixels();
        test_name = "wide_scroll";
        flip  <= 1'b0;
        wide  <= 1'b1;
        v_adj <= 10'd300;
        h_adj <= 10'd700;
        run_lines(lines_per_cfg);

        pause_pixels();
        test_name = "disabled";
        wide    <= 1'b0;
        enabled <= 1'b0;
        v_adj   <= 10'd17;
        h_adj   <= 10'd45;
        run_lines(lines_per_cfg);
        pause_pixels();

        if (disabled_reqs == 0) begin
            protocol_count++;
            $display("No ROM request was issued while the layer was disabled");
        end
        $display("Errors: %0d mismatches, %0d protocol failures", mismatch_count, protocol_count);
        if ((mismatch_count + protocol_count) == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tile_layer.f
rtl/tile_layer_pkg.sv
rtl/scroll_counter.sv
rtl/fetch_sequencer.sv
rtl/tile_pixel_pipe.sv
rtl/tile_layer.sv
sim/tb_tile_layer_models.sv
sim/tb_tile_layer.sv

//--- Bender.yml
package:
  name: tile_layer

sources:
  # Package first, then the leaf blocks, then the top level
  - rtl/tile_layer_pkg.sv
  - rtl/scroll_counter.sv
  - rtl/fetch_sequencer.sv
  - rtl/tile_pixel_pipe.sv
  - rtl/tile_layer.sv

  - target: simulation
    files:
      - sim/tb_tile_layer_models.sv
      - sim/tb_tile_layer.sv
